// ==== hw/isaPkg.sv ====
package isaPkg;

	localparam int DATA_W = 16; // Operand and result width
	localparam int TAG_W  = 3;  // Result tag width
	localparam int OP_W   = 3;
	localparam int DISP_W = OP_W + TAG_W + 2 * (DATA_W + 1); // 40 bits

	// Dispatch word field positions, MSB first: op, destTag, aRdy, a, bRdy, b
	localparam int OP_LSB    = 37;
	localparam int DEST_LSB  = 34;
	localparam int A_RDY_BIT = 33;
	localparam int A_LSB     = 17;
	localparam int B_RDY_BIT = 16;
	localparam int B_LSB     = 0;

	typedef logic [DATA_W-1:0] dataT;
	typedef logic [DATA_W:0]   rawT;  // Bit 16 is the carry
	typedef logic [TAG_W-1:0]  tagT;
	typedef logic [DISP_W-1:0] dispWordT;

	// ALU opcodes
	typedef enum logic [OP_W-1:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		SLL,
		SRL,
		SLT // Signed set-less-than
	} opT;

endpackage

// ==== hw/rsPkg.sv ====
package rsPkg;

	// Station depth, power of two so the pointer wraps on its own
	localparam int RS_ENTRIES = 4;
	localparam int RS_IDX_W   = $clog2(RS_ENTRIES);

	typedef logic [RS_IDX_W-1:0]   rsIdxT; // Entry index and select pointer
	typedef logic [RS_ENTRIES-1:0] rsVecT; // Request and grant vectors

endpackage

// ==== hw/aluIfs.sv ====
// Decoded instruction from dispatch decode into the station
interface dispatchIf;
	import isaPkg::*;

	logic valid;   // One-cycle strobe
	opT   op;
	tagT  destTag;
	logic aRdy;    // Operand a holds a value, else a tag in its low bits
	dataT a;
	logic bRdy;
	dataT b;

	modport source (output valid, op, destTag, aRdy, a, bRdy, b);
	modport sink   (input valid, op, destTag, aRdy, a, bRdy, b);
endinterface

// Granted entry from the station into the ALU
interface issueIf;
	import isaPkg::*;

	logic valid; // High in any cycle with a grant
	opT   op;
	tagT  tag;
	dataT a;
	dataT b;

	modport source (output valid, op, tag, a, b);
	modport sink   (input valid, op, tag, a, b);
endinterface

// ==== hw/dispatchDecode.sv ====
module dispatchDecode (
	input  logic             clk,
	input  logic             arstN,
	input  logic             flush,
	input  logic             wbCyc,
	input  logic             wbStb,
	input  logic             wbWe,
	input  isaPkg::dispWordT wbDat,
	output logic             wbAck,
	input  logic             rsFull,
	input  logic             cdbValid,
	input  isaPkg::tagT      cdbTag,
	input  isaPkg::dataT     cdbValue,
	dispatchIf.source        dsp
);
	import isaPkg::*;

	logic accept;
	logic aRdyIn, bRdyIn;
	dataT aIn, bIn;
	logic aHit, bHit; // Source tag on the CDB this very cycle

	// Write cycle with room in the station, one ack per request
	assign accept = wbCyc && wbStb && wbWe && !wbAck && !rsFull && !flush;

	// Unpack operand fields
	assign aRdyIn = wbDat[A_RDY_BIT];
	assign aIn    = wbDat[A_LSB +: DATA_W];
	assign bRdyIn = wbDat[B_RDY_BIT];
	assign bIn    = wbDat[B_LSB +: DATA_W];

	// Broadcast in the accept cycle would be missed by the station
	assign aHit = !aRdyIn && cdbValid && (aIn[TAG_W-1:0] == cdbTag);
	assign bHit = !bRdyIn && cdbValid && (bIn[TAG_W-1:0] == cdbTag);

	// Strobe shares the ack cycle
	assign dsp.valid = wbAck;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wbAck <= 1'b0;
		end else begin
			wbAck <= accept; // Drops after one cycle via !wbAck term
		end
	end

	// Decoded fields, valid alongside wbAck
	always_ff @(posedge clk) begin
		if (accept) begin
			dsp.op      <= opT'(wbDat[OP_LSB +: OP_W]);
			dsp.destTag <= wbDat[DEST_LSB +: TAG_W];
			dsp.aRdy    <= aRdyIn || aHit;
			dsp.a       <= aHit ? cdbValue : aIn;
			dsp.bRdy    <= bRdyIn || bHit;
			dsp.b       <= bHit ? cdbValue : bIn;
		end
	end

	// Ack only answers a live bus request
	ackNeedsRequest: assert property (@(posedge clk) disable iff (!arstN)
		$rose(wbAck) |-> $past(wbCyc && wbStb));

endmodule

// ==== hw/issueSelect.sv ====
module issueSelect (
	input  logic         clk,
	input  logic         arstN,
	input  logic         flush,
	input  rsPkg::rsVecT requests,
	output rsPkg::rsVecT grants
);
	import rsPkg::*;

	rsIdxT pointer;    // Highest priority entry this cycle
	rsIdxT nxtPointer;
	rsIdxT probe;
	logic  found;

	// First requester at or after the pointer, wrapping
	always_comb begin
		grants     = '0;
		nxtPointer = pointer; // Hold when nothing granted
		found      = 1'b0;
		probe      = pointer;
		for (int k = 0; k < RS_ENTRIES; k++) begin
			probe = pointer + rsIdxT'(k); // Wraps modulo entry count
			if (!found && requests[probe]) begin
				grants[probe] = 1'b1;
				nxtPointer    = probe + rsIdxT'(1); // Winner drops to lowest priority
				found         = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pointer <= '0;
		end else if (flush) begin
			pointer <= '0;
		end else begin
			pointer <= nxtPointer;
		end
	end

	// At most one grant and only to a requester
	grantLegal: assert property (@(posedge clk) disable iff (!arstN)
		$onehot0(grants) && ((grants & ~requests) == '0));

endmodule

// ==== hw/reservationStation.sv ====
module reservationStation (
	input  logic         clk,
	input  logic         arstN,
	input  logic         flush,
	dispatchIf.sink      dsp,
	issueIf.source       iss,
	output logic         rsFull,
	input  logic         cdbValid,
	input  isaPkg::tagT  cdbTag,
	input  isaPkg::dataT cdbValue
);
	import isaPkg::*;
	import rsPkg::*;

	logic [RS_ENTRIES-1:0] busy;
	logic [RS_ENTRIES-1:0] aRdy;
	logic [RS_ENTRIES-1:0] bRdy;
	opT   op      [RS_ENTRIES];
	tagT  destTag [RS_ENTRIES];
	dataT aVal    [RS_ENTRIES]; // Value, or source tag in the low bits
	dataT bVal    [RS_ENTRIES];

	rsVecT requests;
	rsVecT grants;
	rsIdxT freeIdx;
	rsIdxT grantIdx;
	logic  aHitIn, bHitIn; // Incoming operand woken during the strobe

	issueSelect uSelect (
		.clk      (clk),
		.arstN    (arstN),
		.flush    (flush),
		.requests (requests),
		.grants   (grants)
	);

	assign rsFull   = &busy;
	assign requests = busy & aRdy & bRdy; // Both operands in hand

	// Lowest free entry
	always_comb begin
		freeIdx = '0;
		for (int i = RS_ENTRIES - 1; i >= 0; i--) begin
			if (!busy[i]) freeIdx = rsIdxT'(i);
		end
	end

	// One-hot grant to index
	always_comb begin
		grantIdx = '0;
		for (int i = 0; i < RS_ENTRIES; i++) begin
			if (grants[i]) grantIdx = rsIdxT'(i);
		end
	end

	// Granted entry straight to the ALU
	assign iss.valid = |grants;
	assign iss.op    = op[grantIdx];
	assign iss.tag   = destTag[grantIdx];
	assign iss.a     = aVal[grantIdx];
	assign iss.b     = bVal[grantIdx];

	assign aHitIn = !dsp.aRdy && cdbValid && (dsp.a[TAG_W-1:0] == cdbTag);
	assign bHitIn = !dsp.bRdy && cdbValid && (dsp.b[TAG_W-1:0] == cdbTag);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			busy <= '0;
		end else if (flush) begin
			busy <= '0; // Drops in-flight dispatch too
		end else begin
			if (iss.valid) busy[grantIdx] <= 1'b0; // Release on issue
			if (dsp.valid) busy[freeIdx] <= 1'b1;  // Never the granted one
		end
	end

	// Entry payload and CDB wake-up
	always_ff @(posedge clk) begin
		for (int i = 0; i < RS_ENTRIES; i++) begin
			if (busy[i] && !aRdy[i] && cdbValid && (aVal[i][TAG_W-1:0] == cdbTag)) begin
				aVal[i] <= cdbValue;
				aRdy[i] <= 1'b1;
			end
			if (busy[i] && !bRdy[i] && cdbValid && (bVal[i][TAG_W-1:0] == cdbTag)) begin
				bVal[i] <= cdbValue;
				bRdy[i] <= 1'b1;
			end
		end
		if (dsp.valid) begin // Target entry is free, no clash with wake-up
			op[freeIdx]      <= dsp.op;
			destTag[freeIdx] <= dsp.destTag;
			aRdy[freeIdx]    <= dsp.aRdy || aHitIn;
			aVal[freeIdx]    <= aHitIn ? cdbValue : dsp.a;
			bRdy[freeIdx]    <= dsp.bRdy || bHitIn;
			bVal[freeIdx]    <= bHitIn ? cdbValue : dsp.b;
		end
	end

	// Decode must hold back while full
	noDispatchWhenFull: assert property (@(posedge clk) disable iff (!arstN)
		dsp.valid |-> !rsFull);

endmodule

// ==== hw/aluExecute.sv ====
module aluExecute (
	input  logic        clk,
	input  logic        arstN,
	input  logic        flush,
	issueIf.sink        iss,
	output logic        exValid,
	output isaPkg::opT  exOp,
	output isaPkg::tagT exTag,
	output isaPkg::rawT exRaw
);
	import isaPkg::*;

	rawT        rawNext;
	logic [3:0] shAmt;

	assign shAmt = iss.b[3:0]; // Shift range 0..15

	always_comb begin
		case (iss.op)
			ADD:     rawNext = {1'b0, iss.a} + {1'b0, iss.b};
			SUB:     rawNext = {1'b0, iss.a} + {1'b0, ~iss.b} + rawT'(1); // Carry means no borrow
			AND:     rawNext = {1'b0, iss.a & iss.b};
			OR:      rawNext = {1'b0, iss.a | iss.b};
			XOR:     rawNext = {1'b0, iss.a ^ iss.b};
			SLL:     rawNext = {1'b0, iss.a << shAmt};
			SRL:     rawNext = {1'b0, iss.a >> shAmt};
			SLT:     rawNext = rawT'($signed(iss.a) < $signed(iss.b));
			default: rawNext = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			exValid <= 1'b0;
		end else if (flush) begin
			exValid <= 1'b0;
		end else begin
			exValid <= iss.valid;
		end
	end

	// Result and opcode carried forward for flag forming
	always_ff @(posedge clk) begin
		if (iss.valid) begin
			exOp  <= iss.op;
			exTag <= iss.tag;
			exRaw <= rawNext;
		end
	end

endmodule

// ==== hw/resultBroadcast.sv ====
module resultBroadcast (
	input  logic         clk,
	input  logic         arstN,
	input  logic         flush,
	input  logic         exValid,
	input  isaPkg::opT   exOp,
	input  isaPkg::tagT  exTag,
	input  isaPkg::rawT  exRaw,
	output logic         cdbValid,
	output isaPkg::tagT  cdbTag,
	output isaPkg::dataT cdbValue,
	output logic         cdbZero,
	output logic         cdbCarry
);
	import isaPkg::*;

	dataT value;
	logic zero;
	logic carry;

	assign value = exRaw[DATA_W-1:0];
	assign zero  = (value == '0);
	assign carry = ((exOp == ADD) || (exOp == SUB)) && exRaw[DATA_W]; // Arithmetic only

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			cdbValid <= 1'b0;
		end else if (flush) begin
			cdbValid <= 1'b0;
		end else begin
			cdbValid <= exValid; // No back-pressure on the CDB
		end
	end

	always_ff @(posedge clk) begin
		if (exValid) begin
			cdbTag   <= exTag;
			cdbValue <= value;
			cdbZero  <= zero;
			cdbCarry <= carry;
		end
	end

	// Each entry issues once, so a tag never repeats back to back
	noRepeatTag: assert property (@(posedge clk) disable iff (!arstN)
		cdbValid && $past(cdbValid) |-> cdbTag != $past(cdbTag));

endmodule

// ==== hw/aluIssueUnit.sv ====
module aluIssueUnit (
	input  logic             clk,
	input  logic             arstN,
	input  logic             flush,
	input  logic             wbCyc,
	input  logic             wbStb,
	input  logic             wbWe,
	input  isaPkg::dispWordT wbDat,
	output logic             wbAck,
	output logic             cdbValid,
	output isaPkg::tagT      cdbTag,
	output isaPkg::dataT     cdbValue,
	output logic             cdbZero,
	output logic             cdbCarry
);
	import isaPkg::*;

	logic rsFull; // Back-pressure into decode
	logic exValid;
	opT   exOp;
	tagT  exTag;
	rawT  exRaw;

	dispatchIf dispBus ();
	issueIf    issueBus ();

	dispatchDecode uDecode (
		.clk      (clk),
		.arstN    (arstN),
		.flush    (flush),
		.wbCyc    (wbCyc),
		.wbStb    (wbStb),
		.wbWe     (wbWe),
		.wbDat    (wbDat),
		.wbAck    (wbAck),
		.rsFull   (rsFull),
		.cdbValid (cdbValid), // Same-cycle bypass
		.cdbTag   (cdbTag),
		.cdbValue (cdbValue),
		.dsp      (dispBus.source)
	);

	reservationStation uStation (
		.clk      (clk),
		.arstN    (arstN),
		.flush    (flush),
		.dsp      (dispBus.sink),
		.iss      (issueBus.source),
		.rsFull   (rsFull),
		.cdbValid (cdbValid), // Wake-up
		.cdbTag   (cdbTag),
		.cdbValue (cdbValue)
	);

	aluExecute uExecute (
		.clk     (clk),
		.arstN   (arstN),
		.flush   (flush),
		.iss     (issueBus.sink),
		.exValid (exValid),
		.exOp    (exOp),
		.exTag   (exTag),
		.exRaw   (exRaw)
	);

	resultBroadcast uResult (
		.clk      (clk),
		.arstN    (arstN),
		.flush    (flush),
		.exValid  (exValid),
		.exOp     (exOp),
		.exTag    (exTag),
		.exRaw    (exRaw),
		.cdbValid (cdbValid),
		.cdbTag   (cdbTag),
		.cdbValue (cdbValue),
		.cdbZero  (cdbZero),
		.cdbCarry (cdbCarry)
	);

endmodule

// ==== test/aluIssueModel.svh ====
`ifndef ALU_ISSUE_MODEL_SVH
`define ALU_ISSUE_MODEL_SVH

localparam int NUM_TAGS = 1 << TAG_W;

// Tag table, one row per result tag
logic inFlight  [NUM_TAGS]; // Dispatched and not yet broadcast
opT   opTab     [NUM_TAGS];
logic aRdyTab   [NUM_TAGS];
dataT aTab      [NUM_TAGS]; // Value, or source tag in the low bits
logic bRdyTab   [NUM_TAGS];
dataT bTab      [NUM_TAGS];
dataT lastValue [NUM_TAGS]; // Latest expected result per tag
logic [31:0] lcgState;

// Numerical Recipes LCG
function automatic logic [31:0] nextRand();
	lcgState = lcgState * 32'd1664525 + 32'd1013904223;
	return lcgState;
endfunction

// Reference ALU, raw 17-bit result
function automatic rawT refAlu(opT op, dataT a, dataT b);
	case (op)
		ADD:     return rawT'(int'(a) + int'(b)); // Sum fits in 17 bits
		SUB:     return {a >= b, dataT'(a - b)}; // Carry set when no borrow
		AND:     return {1'b0, a & b};
		OR:      return {1'b0, a | b};
		XOR:     return {1'b0, a ^ b};
		SLL:     return {1'b0, a << b[3:0]};
		SRL:     return {1'b0, a >> b[3:0]};
		default: return ($signed(a) < $signed(b)) ? rawT'(1) : '0; // SLT
	endcase
endfunction

// Carry only means something for arithmetic
function automatic logic carryOf(opT op, dataT a, dataT b);
	case (op)
		ADD:     return (int'(a) + int'(b)) > 65535; // Sum overflows 16 bits
		SUB:     return a >= b; // No borrow
		default: return 1'b0;
	endcase
endfunction

// Source already off the CDB, take its value
function automatic void resolveOperands(tagT t);
	if (!aRdyTab[t] && !inFlight[aTab[t][TAG_W-1:0]]) begin
		aTab[t]    = lastValue[aTab[t][TAG_W-1:0]];
		aRdyTab[t] = 1'b1;
	end
	if (!bRdyTab[t] && !inFlight[bTab[t][TAG_W-1:0]]) begin
		bTab[t]    = lastValue[bTab[t][TAG_W-1:0]];
		bRdyTab[t] = 1'b1;
	end
endfunction

// Dispatch word, op at the top
function automatic dispWordT packWord(tagT t);
	return {opTab[t], t, aRdyTab[t], aTab[t], bRdyTab[t], bTab[t]};
endfunction

function automatic int inFlightCount();
	int n;
	n = 0;
	for (int k = 0; k < NUM_TAGS; k++) begin
		if (inFlight[k]) n++;
	end
	return n;
endfunction

`endif

// ==== test/aluIssueTb.sv ====
module aluIssueTb;
	import isaPkg::*;

	logic     clk, arstN, flush;
	logic     wbCyc, wbStb, wbWe, wbAck;
	dispWordT wbDat;
	logic     cdbValid, cdbZero, cdbCarry;
	tagT      cdbTag;
	dataT     cdbValue;

	int  errors, checks, broadcasts, dispatched, flushed, testErrBase;
	tagT cdbLog[$]; // Broadcast order

	`include "aluIssueModel.svh"

	aluIssueUnit u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic checkData(input string name, input dataT exp, input dataT got);
		checks++;
		if (got !== exp) begin
			$display("MISMATCH %s expected %h got %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic checkTag(input string name, input tagT exp, input tagT got);
		checks++;
		if (got !== exp) begin
			$display("MISMATCH %s expected %h got %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic checkFlag(input string name, input logic exp, input logic got);
		checks++;
		if (got !== exp) begin
			$display("MISMATCH %s expected %h got %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic abortRun(input string why);
		$display("TIMEOUT: %s", why);
		$display("Result: FAILED");
		$finish;
	endtask

	task automatic endTest(input string name);
		$display("test %-12s done, %0d errors", name, errors - testErrBase);
		testErrBase = errors;
	endtask

	// Lowest tag not in flight
	task automatic waitFreeTag(output tagT t);
		int   guard;
		logic found;
		guard = 0;
		found = 1'b0;
		t     = '0;
		while (!found) begin
			for (int k = 0; k < NUM_TAGS; k++) begin
				if (!found && !inFlight[k]) begin
					t     = tagT'(k);
					found = 1'b1;
				end
			end
			if (!found) begin
				@(negedge clk);
				guard++;
				if (guard > 200) abortRun("no result tag came free");
			end
		end
	endtask

	// Ready value or an in-flight tag, coin flip
	task automatic randOperand(output logic rdy, output dataT v);
		logic [31:0] r;
		tagT         t;
		r   = nextRand();
		rdy = 1'b1;
		v   = r[31:16];
		if (r[0]) begin
			for (int k = 0; k < NUM_TAGS; k++) begin
				t = tagT'(k) + r[10:8];
				if (rdy && inFlight[t]) begin
					rdy = 1'b0;
					v   = dataT'(t);
				end
			end
		end
	endtask

	// One Wishbone write, operands refreshed from the CDB while unacked
	task automatic dispatchOp(input opT op, input logic aRdy, input dataT a, input logic bRdy,
			input dataT b, input logic pickDest, input tagT destIn, output tagT dest,
			output int waited);
		dest = destIn;
		if (pickDest) waitFreeTag(dest);
		opTab[dest]   = op;
		aRdyTab[dest] = aRdy;
		aTab[dest]    = a;
		bRdyTab[dest] = bRdy;
		bTab[dest]    = b;
		resolveOperands(dest); // Before marking, a freed source may equal dest
		inFlight[dest] = 1'b1;
		wbDat  = packWord(dest);
		wbCyc  = 1'b1;
		wbStb  = 1'b1;
		wbWe   = 1'b1;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			if (waited > 100) abortRun("wbAck never came for a dispatch");
			if (!wbAck) begin
				resolveOperands(dest);
				wbDat = packWord(dest);
			end
		end while (!wbAck);
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe  = 1'b0;
		dispatched++;
	endtask

	task automatic drain();
		int guard;
		guard = 0;
		while (inFlightCount() != 0) begin
			@(negedge clk);
			guard++;
			if (guard > 300) abortRun("results still missing after drain");
		end
	endtask

	// CDB monitor, wakes model operands like the station does
	task automatic watchCdb();
		rawT raw;
		tagT t;
		forever begin
			@(negedge clk);
			if (cdbValid) begin
				t = cdbTag;
				broadcasts++;
				cdbLog.push_back(t);
				if (!inFlight[t]) begin
					$display("ERROR: tag %h broadcast while not in flight", t);
					errors++;
				end else if (!aRdyTab[t] || !bRdyTab[t]) begin
					$display("ERROR: tag %h broadcast before its sources", t);
					errors++;
				end else begin
					raw = refAlu(opTab[t], aTab[t], bTab[t]);
					checkData("cdbValue", raw[DATA_W-1:0], cdbValue);
					checkFlag("cdbZero", raw[DATA_W-1:0] == '0, cdbZero);
					checkFlag("cdbCarry", carryOf(opTab[t], aTab[t], bTab[t]), cdbCarry);
					lastValue[t] = raw[DATA_W-1:0];
					inFlight[t]  = 1'b0;
					for (int k = 0; k < NUM_TAGS; k++) begin
						if (inFlight[k]) resolveOperands(tagT'(k));
					end
				end
			end
		end
	endtask

	initial begin
		tagT         d, u;
		tagT         w [4];
		int          waited, start, hits, seen;
		logic        ar, br;
		dataT        av, bv;
		logic [31:0] r;
		lcgState = 32'h7edbdc2c;
		arstN    = 1'b0;
		flush    = 1'b0;
		wbCyc    = 1'b0;
		wbStb    = 1'b0;
		wbWe     = 1'b0;
		wbDat    = '0;
		{errors, checks, broadcasts, dispatched, flushed, testErrBase} = '0;
		for (int k = 0; k < NUM_TAGS; k++) begin
			inFlight[k]  = 1'b0;
			lastValue[k] = '0;
		end
		repeat (10) @(negedge clk);
		arstN = 1'b1;
		checkFlag("wbAck", 1'b0, wbAck);
		checkFlag("cdbValid", 1'b0, cdbValid);
		fork
			watchCdb();
		join_none

		// Every opcode, random and equal operands
		for (int k = 0; k < 8; k++) begin
			r = nextRand();
			dispatchOp(opT'(k[2:0]), 1'b1, r[15:0], 1'b1, r[31:16], 1'b1, '0, d, waited);
			dispatchOp(opT'(k[2:0]), 1'b1, r[15:0], 1'b1, r[15:0], 1'b1, '0, d, waited);
		end
		dispatchOp(ADD, 1'b1, 16'hffff, 1'b1, 16'h0001, 1'b1, '0, d, waited); // Zero and carry
		drain();
		endTest("opcodes");

		// Dependents at growing distance, covers both bypass points
		for (int gap = 0; gap < 5; gap++) begin
			r = nextRand();
			dispatchOp(ADD, 1'b1, r[15:0], 1'b1, r[31:16], 1'b1, '0, u, waited);
			repeat (gap) @(negedge clk);
			dispatchOp(SUB, 1'b0, dataT'(u), 1'b1, r[23:8], 1'b1, '0, d, waited);
			dispatchOp(XOR, 1'b0, dataT'(d), 1'b0, dataT'(u), 1'b1, '0, d, waited);
			drain();
		end
		endTest("chain");

		// Three waiters on a tag whose producer comes last
		waitFreeTag(u);
		inFlight[u] = 1'b1;
		aRdyTab[u]  = 1'b1;
		bRdyTab[u]  = 1'b1;
		for (int k = 0; k < 3; k++) begin
			r = nextRand();
			dispatchOp(opT'(r[2:0]), 1'b0, dataT'(u), 1'b1, r[31:16], 1'b1, '0, w[k], waited);
		end
		start = cdbLog.size();
		dispatchOp(ADD, 1'b1, 16'h1234, 1'b1, 16'h4321, 1'b0, u, d, waited); // Fills the station
		dispatchOp(OR, 1'b0, dataT'(u), 1'b1, 16'h00f0, 1'b1, '0, w[3], waited);
		if (waited < 3) begin
			$display("ERROR: wbAck came while the station was full");
			errors++;
		end
		drain();
		endTest("backpressure");

		// Four entries woken together, each broadcast once
		if (cdbLog.size() != start + 5) begin
			$display("ERROR: expected 5 broadcasts, saw %0d", cdbLog.size() - start);
			errors++;
		end else begin
			checkTag("cdbTag", u, cdbLog[start]);
			for (int k = 0; k < 4; k++) begin
				hits = 0;
				for (int j = 1; j < 5; j++) begin
					if (cdbLog[start + j] == w[k]) hits++;
				end
				if (hits != 1) begin
					$display("ERROR: tag %h broadcast %0d times in the ready group", w[k], hits);
					errors++;
				end
			end
		end
		endTest("fairness");

		// Flush with waiting entries and two ready ops in the pipe, then quiet CDB
		waitFreeTag(u);
		inFlight[u] = 1'b1;
		aRdyTab[u]  = 1'b1;
		bRdyTab[u]  = 1'b1;
		for (int k = 0; k < 2; k++) begin
			r = nextRand();
			dispatchOp(AND, 1'b0, dataT'(u), 1'b1, r[15:0], 1'b1, '0, d, waited);
		end
		r = nextRand();
		dispatchOp(ADD, 1'b1, r[15:0], 1'b1, r[31:16], 1'b1, '0, d, waited); // Leaves execute at flush
		dispatchOp(XOR, 1'b1, r[31:16], 1'b1, r[15:0], 1'b1, '0, d, waited); // Strobe meets flush
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		for (int k = 0; k < NUM_TAGS; k++) begin
			if (inFlight[k]) flushed++;
			inFlight[k] = 1'b0;
		end
		seen = 0;
		for (int c = 0; c < 20; c++) begin
			if (cdbValid) seen++; // First look is the cycle right after flush
			@(negedge clk);
		end
		if (seen != 0) begin
			$display("ERROR: cdbValid seen in %0d cycles after flush", seen);
			errors++;
		end
		dispatchOp(SUB, 1'b1, 16'h0005, 1'b1, 16'h0005, 1'b1, '0, d, waited);
		drain();
		endTest("flush");

		// Random mix with random dependencies and gaps
		for (int n = 0; n < 60; n++) begin
			r = nextRand();
			randOperand(ar, av);
			randOperand(br, bv);
			dispatchOp(opT'(r[2:0]), ar, av, br, bv, 1'b1, '0, d, waited);
			repeat (r[5:4]) @(negedge clk);
		end
		drain();
		endTest("random");

		$display("Totals: %0d checks, %0d errors, %0d dispatches, %0d broadcasts, %0d flushed",
			checks, errors, dispatched, broadcasts, flushed);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+test
hw/isaPkg.sv
hw/rsPkg.sv
hw/aluIfs.sv
hw/dispatchDecode.sv
hw/issueSelect.sv
hw/reservationStation.sv
hw/aluExecute.sv
hw/resultBroadcast.sv
hw/aluIssueUnit.sv
test/aluIssueTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the ALU issue testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module aluIssueTb -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
	echo "No result line in $LOG"
	exit 1
fi
exit 0
